// File: sources.f
logic/pix_pkg.sv
logic/pixel_compactor.sv
logic/lane_fifo.sv
logic/line_counter.sv
logic/frame_sequencer.sv
logic/stream_packer.sv
test/stream_packer_tb.sv

// File: Makefile
TOP := stream_packer_tb
LOG := sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "test failed" >> $(LOG)
	cat $(LOG)
	! grep -q "test failed" $(LOG)

obj_dir/V$(TOP): sources.f $(wildcard logic/*.sv test/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f

lint:
	verilator --lint-only -Wall --timing --top-module stream_packer -f sources.f

clean:
	rm -rf obj_dir $(LOG)

// File: test/stream_packer_tb.sv
// Stream packer testbench with random holed beats, a queue reference model and back-pressure
`timescale 1ns/10ps

module stream_packer_tb;

    localparam int NUM_BEATS   = 400;
    localparam int CLK_NS      = 20;
    localparam int WATCHDOG_NS = NUM_BEATS * 40 * CLK_NS;
    localparam int FRAME_BEATS = pix_pkg::LINE_BEATS * pix_pkg::FRAME_LINES;

    logic               clk;
    logic               rst_n;
    logic               in_valid;
    pix_pkg::in_beat_t  in_beat;
    logic               in_ready;
    logic               out_valid;
    pix_pkg::out_beat_t out_beat;
    logic               out_ready;

    int seed;

    // Kept pixels not yet matched to an output beat, oldest first
    pix_pkg::pixel_t exp_q [$];

    int kept_total;
    int out_beats;
    int empty_beats;
    int full_beats;
    int fill_cycles;
    int stall_cycles;

    int pixel_errs;
    int flag_errs;
    int count_errs;
    int other_errs;

    // Beat seen under back-pressure at the previous edge
    logic               stalled;
    pix_pkg::out_beat_t held_beat;

    stream_packer stream_packer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_beat  (out_beat),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    task automatic check_pixels(input string name,
                                input pix_pkg::pixel_t [pix_pkg::LANES-1:0] got,
                                input pix_pkg::pixel_t [pix_pkg::LANES-1:0] expected);
        if (got !== expected) begin
            pixel_errs++;
            $display("error: %s got %h expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            flag_errs++;
            $display("error: %s got %h expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic check_count(input string name,
                               input pix_pkg::lane_cnt_t got,
                               input pix_pkg::lane_cnt_t expected);
        if (got !== expected) begin
            count_errs++;
            $display("error: %s got %h expected %h at %0t", name, got, expected, $time);
        end
    endtask

    // Random pixels, with some beats fully empty or fully kept
    task automatic make_beat(output pix_pkg::in_beat_t beat);
        int pick;
        pick = $random(seed) & 7;
        for (int i = 0; i < pix_pkg::LANES; i++) begin
            beat.pixels[i] = pix_pkg::pixel_t'($random(seed));
        end
        if (pick == 0) begin
            beat.keep = '0;
        end else if (pick == 1) begin
            beat.keep = '1;
        end else begin
            beat.keep = pix_pkg::lane_mask_t'($random(seed));
        end
    endtask

    // Lowest kept lane arrives first
    task automatic record_input(input pix_pkg::in_beat_t beat);
        for (int i = 0; i < pix_pkg::LANES; i++) begin
            if (beat.keep[i]) begin
                exp_q.push_back(beat.pixels[i]);
                kept_total++;
            end
        end
        if (beat.keep == '0) begin
            empty_beats++;
        end
        if (beat.keep == '1) begin
            full_beats++;
        end
    endtask

    task automatic score_output(input pix_pkg::out_beat_t beat);
        pix_pkg::pixel_t [pix_pkg::LANES-1:0] exp_pixels;
        if (exp_q.size() < pix_pkg::LANES) begin
            other_errs++;
            $display("output beat %0d appeared without four pending input pixels at %0t",
                     out_beats, $time);
        end else begin
            for (int i = 0; i < pix_pkg::LANES; i++) begin
                exp_pixels[i] = exp_q.pop_front();
            end
            check_pixels("out_beat.pixels", beat.pixels, exp_pixels);
        end
        check_flag("out_beat.last", beat.last,
                   (out_beats % pix_pkg::LINE_BEATS) == (pix_pkg::LINE_BEATS - 1));
        check_flag("out_beat.sof", beat.sof, (out_beats % FRAME_BEATS) == 0);
        out_beats++;
    endtask

    // Monitor samples the values present just before each rising edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (stalled) begin
                check_flag("out_valid", out_valid, 1'b1);
                check_pixels("out_beat.pixels", out_beat.pixels, held_beat.pixels);
                check_flag("out_beat.last", out_beat.last, held_beat.last);
                check_flag("out_beat.sof", out_beat.sof, held_beat.sof);
            end
            if (in_valid && in_ready) begin
                record_input(in_beat);
            end
            if (out_valid && out_ready) begin
                score_output(out_beat);
            end
            if (!in_ready) begin
                fill_cycles++;
            end
            stalled   = out_valid && !out_ready;
            held_beat = out_beat;
            if (stalled) begin
                stall_cycles++;
            end
        end else begin
            stalled = 1'b0;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before the run completed", WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

    initial begin
        int   sent;
        int   quiet;
        logic took;
        seed      = 32'h23bb_d335;
        stalled   = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_beat   = '0;
        out_ready = 1'b0;

        // Outputs stay idle through reset and just after it
        repeat (3) begin
            @(posedge clk);
            check_flag("out_valid", out_valid, 1'b0);
            check_flag("in_ready", in_ready, 1'b1);
        end
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("in_ready", in_ready, 1'b1);
        #2;

        // A waiting beat stays valid and stable until it transfers
        sent = 0;
        while (sent < NUM_BEATS) begin
            @(posedge clk);
            took = in_valid && in_ready;
            #2;
            out_ready = ($random(seed) & 1) != 0;
            if (took) begin
                sent++;
            end
            if (!in_valid || took) begin
                if (sent < NUM_BEATS && ($random(seed) & 3) != 0) begin
                    make_beat(in_beat);
                    in_valid = 1'b1;
                end else begin
                    in_valid = 1'b0;
                end
            end
        end

        // Drain until the output has been quiet for a while
        out_ready = 1'b1;
        quiet     = 0;
        while (quiet < 16) begin
            @(posedge clk);
            if (out_valid) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end

        if (out_beats != kept_total / pix_pkg::LANES) begin
            other_errs++;
            $display("%0d output beats sent for %0d kept input pixels", out_beats, kept_total);
        end
        check_count("leftover pixels",
                    pix_pkg::lane_cnt_t'(kept_total - out_beats * pix_pkg::LANES),
                    pix_pkg::lane_cnt_t'(kept_total % pix_pkg::LANES));
        if (empty_beats == 0 || full_beats == 0) begin
            other_errs++;
            $display("stimulus did not include both all-empty and all-full beats");
        end
        if (fill_cycles == 0 || stall_cycles == 0) begin
            other_errs++;
            $display("back-pressure never stalled the output or filled the lane FIFOs");
        end

        $display("errors: pixels %0d, flags %0d, counts %0d, other %0d",
                 pixel_errs, flag_errs, count_errs, other_errs);
        if (pixel_errs + flag_errs + count_errs + other_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: logic/stream_packer.sv
// Stream packer top that turns holed pixel beats into full four-pixel beats with line and frame marks
`timescale 1ns/10ps

module stream_packer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  pix_pkg::in_beat_t  in_beat,
    output logic               in_ready,
    output logic               out_valid,
    output pix_pkg::out_beat_t out_beat,
    input  logic               out_ready
);

    logic xfer;

    pix_pkg::pixel_t [pix_pkg::LANES-1:0] wr_pixels;
    pix_pkg::lane_mask_t                  wr_mask;

    // One entry per lane FIFO
    pix_pkg::pixel_t     rd_pixels [pix_pkg::LANES];
    pix_pkg::lane_mask_t fifo_empty;
    pix_pkg::lane_mask_t fifo_full;

    logic rd;
    logic line_end;
    logic frame_end;
    logic out_last;
    logic out_sof;

    // Accept only while every lane has room
    assign in_ready = !(|fifo_full);
    assign xfer     = in_valid && in_ready;

    pixel_compactor pixel_compactor_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .beat      (in_beat),
        .xfer      (xfer),
        .wr_pixels (wr_pixels),
        .wr_mask   (wr_mask)
    );

    for (genvar g = 0; g < pix_pkg::LANES; g++) begin : g_lane
        lane_fifo lane_fifo_inst (
            .clk      (clk),
            .rst_n    (rst_n),
            .wr       (wr_mask[g]),
            .wr_pixel (wr_pixels[g]),
            .rd       (rd),
            .rd_pixel (rd_pixels[g]),
            .empty    (fifo_empty[g]),
            .full     (fifo_full[g])
        );
    end

    line_counter line_counter_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (rd),
        .line_end  (line_end),
        .frame_end (frame_end)
    );

    frame_sequencer frame_sequencer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .fifo_empty (fifo_empty),
        .out_ready  (out_ready),
        .line_end   (line_end),
        .frame_end  (frame_end),
        .rd         (rd),
        .out_valid  (out_valid),
        .out_last   (out_last),
        .out_sof    (out_sof)
    );

    // Lane 0 carries the oldest pixel of the group
    always_comb begin
        for (int i = 0; i < pix_pkg::LANES; i++) begin
            out_beat.pixels[i] = rd_pixels[i];
        end
        out_beat.last = out_last;
        out_beat.sof  = out_sof;
    end

endmodule

// File: logic/frame_sequencer.sv
// Frame sequencer FSM issuing lane FIFO reads and the output valid, last and start of frame
`timescale 1ns/10ps

module frame_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  pix_pkg::lane_mask_t fifo_empty,
    input  logic                out_ready,
    input  logic                line_end,
    input  logic                frame_end,
    output logic                rd,
    output logic                out_valid,
    output logic                out_last,
    output logic                out_sof
);

    pix_pkg::seq_state_t state;

    // Output register can take a new beat
    logic out_free;

    assign out_free = !out_valid || out_ready;

    // A full group is ready once every lane holds a pixel
    assign rd = !(|fifo_empty) && out_free;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            out_sof   <= 1'b0;
        end else if (out_free) begin
            out_valid <= rd;
            if (rd) begin
                out_last <= line_end;
                out_sof  <= (state == pix_pkg::SEQ_IDLE);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= pix_pkg::SEQ_IDLE;
        end else if (rd) begin
            // Last beat of the frame rearms the start-of-frame mark
            if (frame_end) begin
                state <= pix_pkg::SEQ_IDLE;
            end else begin
                state <= pix_pkg::SEQ_LINE;
            end
        end
    end

    // Stalled beat keeps its valid and its flags
    assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable({out_last, out_sof})))
        else $error("frame_sequencer: output beat changed under back-pressure");

endmodule

// File: logic/line_counter.sv
// Line counter tracking the output beat within a line and the line within a frame
`timescale 1ns/10ps

module line_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic step,
    output logic line_end,
    output logic frame_end
);

    pix_pkg::beat_cnt_t beat_idx;
    pix_pkg::line_cnt_t line_idx;

    // Flags describe the beat currently being read
    assign line_end  = (beat_idx == pix_pkg::beat_cnt_t'(pix_pkg::LINE_BEATS - 1));
    assign frame_end = line_end &&
                       (line_idx == pix_pkg::line_cnt_t'(pix_pkg::FRAME_LINES - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_idx <= '0;
            line_idx <= '0;
        end else if (step) begin
            if (line_end) begin
                beat_idx <= '0;
                // Wrap lines at the frame boundary
                if (frame_end) begin
                    line_idx <= '0;
                end else begin
                    line_idx <= line_idx + 1'b1;
                end
            end else begin
                beat_idx <= beat_idx + 1'b1;
            end
        end
    end

    // Line index never leaves the frame
    assert property (@(posedge clk) disable iff (!rst_n)
        line_idx < pix_pkg::line_cnt_t'(pix_pkg::FRAME_LINES))
        else $error("line_counter: line index out of frame");

endmodule

// File: logic/lane_fifo.sv
// Lane FIFO holding the pixels of one output lane, read data registered on rd
`timescale 1ns/10ps

module lane_fifo (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            wr,
    input  pix_pkg::pixel_t wr_pixel,
    input  logic            rd,
    output pix_pkg::pixel_t rd_pixel,
    output logic            empty,
    output logic            full
);

    typedef logic [$clog2(pix_pkg::FIFO_DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(pix_pkg::FIFO_DEPTH+1)-1:0] cnt_t;

    pix_pkg::pixel_t mem [pix_pkg::FIFO_DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;

    assign empty = (count == '0);
    assign full  = (count == cnt_t'(pix_pkg::FIFO_DEPTH));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= (wr_ptr == ptr_t'(pix_pkg::FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= (rd_ptr == ptr_t'(pix_pkg::FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous read and write leaves the level unchanged
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= wr_pixel;
        end
        if (rd) begin
            rd_pixel <= mem[rd_ptr];
        end
    end

    // in_ready at the top level must hold back writes to a full lane
    assert property (@(posedge clk) disable iff (!rst_n) wr |-> !full)
        else $error("lane_fifo: write while full");

    // Sequencer reads only when every lane has data
    assert property (@(posedge clk) disable iff (!rst_n) rd |-> !empty)
        else $error("lane_fifo: read while empty");

endmodule

// File: logic/pixel_compactor.sv
// Pixel compactor that packs kept lanes low and rotates them onto the next free lane FIFO
`timescale 1ns/10ps

module pixel_compactor (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  pix_pkg::in_beat_t                       beat,
    input  logic                                    xfer,
    output pix_pkg::pixel_t [pix_pkg::LANES-1:0]    wr_pixels,
    output pix_pkg::lane_mask_t                     wr_mask
);

    // Kept pixels in arrival order, lane 0 first
    pix_pkg::pixel_t [pix_pkg::LANES-1:0] packed_pixels;
    pix_pkg::lane_mask_t                  packed_mask;
    pix_pkg::lane_cnt_t                   valid_cnt;

    // After rotation by the write position
    pix_pkg::pixel_t [pix_pkg::LANES-1:0] rot_pixels;
    pix_pkg::lane_mask_t                  rot_mask;

    // Lane FIFO that receives the next kept pixel
    pix_pkg::lane_idx_t wr_pos;

    // Each kept lane goes to the slot given by the kept lanes below it
    always_comb begin
        pix_pkg::lane_cnt_t run;
        run           = '0;
        packed_pixels = '0;
        packed_mask   = '0;
        for (int i = 0; i < pix_pkg::LANES; i++) begin
            if (beat.keep[i]) begin
                packed_pixels[pix_pkg::lane_idx_t'(run)] = beat.pixels[i];
                packed_mask[pix_pkg::lane_idx_t'(run)]   = 1'b1;
                run = run + 1'b1;
            end
        end
        valid_cnt = run;
    end

    // Slot j lands on FIFO (wr_pos + j) mod LANES
    always_comb begin
        pix_pkg::lane_idx_t dst;
        rot_pixels = '0;
        rot_mask   = '0;
        for (int j = 0; j < pix_pkg::LANES; j++) begin
            dst = pix_pkg::lane_idx_t'((int'(wr_pos) + j) % pix_pkg::LANES);
            if (packed_mask[j]) begin
                rot_pixels[dst] = packed_pixels[j];
                rot_mask[dst]   = 1'b1;
            end
        end
    end

    assign wr_pixels = rot_pixels;
    assign wr_mask   = rot_mask & {pix_pkg::LANES{xfer}};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_pos <= '0;
        end else if (xfer) begin
            wr_pos <= pix_pkg::lane_idx_t'((int'(wr_pos) + int'(valid_cnt)) % pix_pkg::LANES);
        end
    end

    // Writes only happen on a transfer
    assert property (@(posedge clk) disable iff (!rst_n)
        (wr_mask != '0) |-> xfer)
        else $error("pixel_compactor: lane write without transfer");

    // Every kept input pixel reaches exactly one lane FIFO
    assert property (@(posedge clk) disable iff (!rst_n)
        xfer |-> ($countones(wr_mask) == $countones(beat.keep)))
        else $error("pixel_compactor: kept pixel count lost in rotation");

endmodule

// File: logic/pix_pkg.sv
// Pixel packer shared widths, frame geometry, beat formats and sequencer states
package pix_pkg;

    // Beat and pixel geometry
    localparam int LANES      = 4;
    localparam int PIXEL_W    = 24;
    localparam int FIFO_DEPTH = 2;

    // Frame geometry, kept small for simulation
    localparam int LINE_BEATS  = 4;
    localparam int FRAME_LINES = 3;

    typedef logic [PIXEL_W-1:0] pixel_t;

    // One bit per pixel lane
    typedef logic [LANES-1:0] lane_mask_t;

    // Lane position or write rotation
    typedef logic [1:0] lane_idx_t;

    // Number of kept lanes in a beat, 0 to LANES
    typedef logic [2:0] lane_cnt_t;

    typedef logic [1:0] beat_cnt_t;
    typedef logic [1:0] line_cnt_t;

    // Upstream beat, lanes may have holes
    typedef struct packed {
        pixel_t [LANES-1:0] pixels;
        lane_mask_t         keep;
    } in_beat_t;

    // Downstream beat, always four pixels
    typedef struct packed {
        pixel_t [LANES-1:0] pixels;
        logic               last;
        logic               sof;
    } out_beat_t;

    // SEQ_IDLE means the next beat read opens a frame
    typedef enum logic {
        SEQ_IDLE,
        SEQ_LINE
    } seq_state_t;

endpackage
